//--- dv/lsu_trace.txt
# columns: name kind op arg1 arg2 expected, numbers in hex; S L F X take addr in arg1 and rt in arg2
# kinds: H host write of reg arg1 with arg2, S store, L load then check rt, F load with no check, O observe reg arg1, X exception with expected address
h_r1 H - 1 f1827304 0
sw_w10 S sw 10 1 0
lw_10 L lw 10 2 f1827304
lb_10 L lb 10 2 00000004
lb_11 L lb 11 2 00000073
lb_12 L lb 12 2 ffffff82
lb_13 L lb 13 2 fffffff1
lbu_12 L lbu 12 2 00000082
lbu_13 L lbu 13 2 000000f1
lh_10 L lh 10 2 00007304
lh_12 L lh 12 2 fffff182
lhu_10 L lhu 10 2 00007304
lhu_12 L lhu 12 2 0000f182
h_r7 H - 7 55aa55aa 0
bg_20 S sw 20 7 0
sb_21 S sb 21 1 0
sb_23 S sb 23 1 0
bg_24 S sw 24 7 0
sb_24 S sb 24 1 0
sh_26 S sh 26 1 0
bg_28 S sw 28 7 0
sh_28 S sh 28 1 0
sb_2a S sb 2a 1 0
bg_30 S sw 30 7 0
swl_30 S swl 30 1 0
swr_32 S swr 32 1 0
bg_34 S sw 34 7 0
swl_35 S swl 35 1 0
swr_37 S swr 37 1 0
swr_39 S swr 39 1 0
swl_3a S swl 3a 1 0
swr_3c S swr 3c 1 0
swl_3f S swl 3f 7 0
chk_20 L lw 20 2 04aa04aa
chk_24 L lw 24 2 73045504
chk_28 L lw 28 2 55047304
chk_30 L lw 30 2 730455f1
chk_34 L lw 34 2 04aaf182
chk_38 L lw 38 2 82f18273
chk_3c L lw 3c 2 55aa55aa
h_r3 H - 3 11223344 0
lwl_10 L lwl 10 3 04223344
lwl_11 L lwl 11 3 73043344
lwl_12 L lwl 12 3 82730444
lwl_13 L lwl 13 3 f1827304
h_r4 H - 4 55667788 0
lwr_13 L lwr 13 4 556677f1
lwr_12 L lwr 12 4 5566f182
lwr_11 L lwr 11 4 55f18273
lwr_10 L lwr 10 4 f1827304
h_r5 H - 5 deadbeef 0
fwd_lw F lw 10 5 0
fwd_sw S sw 50 5 0
fwd_chk L lw 50 6 f1827304
h_r5b H - 5 01020304 0
fwd_lwl F lwl 11 5 0
fwd_sw2 S sw 54 5 0
fwd_chk2 L lw 54 6 73040304
exc_lw X lw 51 2 51
exc_lh X lh 53 2 53
exc_lhu X lhu 55 2 55
keep_r2 O - 2 0 55aa55aa
exc_sw X sw 52 1 52
exc_sh X sh 55 1 55
keep_50 L lw 50 6 f1827304
keep_54 L lw 54 6 73040304

//--- dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_lsu.sv
`default_nettype none

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;

    typedef logic [63:0]  tok_t;
    typedef logic [127:0] name_t;

    localparam int MAX_LINES       = 128;
    localparam int CYCLES_PER_LINE = 20;

    logic      clk;
    logic      rst;
    logic      req_valid;
    load_op_t  req_load_op;
    store_op_t req_store_op;
    mem_addr_t req_addr;
    reg_idx_t  req_rt;
    logic      host_we;
    reg_idx_t  host_idx;
    word_t     host_wdata;
    reg_idx_t  obs_idx;
    word_t     obs_data;
    logic      exc_valid;
    logic      exc_store;
    mem_addr_t exc_addr;

    name_t       t_name [MAX_LINES];
    tok_t        t_kind [MAX_LINES];
    tok_t        t_op   [MAX_LINES];
    logic [31:0] t_a    [MAX_LINES];
    logic [31:0] t_b    [MAX_LINES];
    logic [31:0] t_exp  [MAX_LINES];
    int          n_lines;
    logic        trace_ready = 1'b0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    lsu_top dut_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_load_op(req_load_op), .req_store_op(req_store_op),
        .req_addr(req_addr), .req_rt(req_rt),
        .host_we(host_we), .host_idx(host_idx), .host_wdata(host_wdata),
        .obs_idx(obs_idx), .obs_data(obs_data),
        .exc_valid(exc_valid), .exc_store(exc_store), .exc_addr(exc_addr)
    );

    task automatic check_value(input name_t name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %0s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    function automatic load_op_t load_code(input tok_t op);
        case (op)
            tok_t'("lw"):  return LOAD_LW;
            tok_t'("lb"):  return LOAD_LB;
            tok_t'("lbu"): return LOAD_LBU;
            tok_t'("lh"):  return LOAD_LH;
            tok_t'("lhu"): return LOAD_LHU;
            tok_t'("lwl"): return LOAD_LWL;
            tok_t'("lwr"): return LOAD_LWR;
            default:       return '0;
        endcase
    endfunction

    function automatic store_op_t store_code(input tok_t op);
        case (op)
            tok_t'("sw"):  return STORE_SW;
            tok_t'("sb"):  return STORE_SB;
            tok_t'("sh"):  return STORE_SH;
            tok_t'("swl"): return STORE_SWL;
            tok_t'("swr"): return STORE_SWR;
            default:       return '0;
        endcase
    endfunction

    task automatic read_trace();
        integer        fd;
        integer        rc;
        logic [1279:0] line;
        name_t         name;
        tok_t          kind;
        tok_t          op;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   e;
        fd = $fopen("dv/lsu_trace.txt", "r");
        if (fd == 0) begin
            stop_with("cannot open the trace file dv/lsu_trace.txt");
        end
        n_lines = 0;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = '0;
            rc = $fgets(line, fd);
            if (rc != 0 && $sscanf(line, "%s %s %s %h %h %h", name, kind, op, a, b, e) == 6) begin
                t_name[n_lines] = name;
                t_kind[n_lines] = kind;
                t_op[n_lines]   = op;
                t_a[n_lines]    = a;
                t_b[n_lines]    = b;
                t_exp[n_lines]  = e;
                n_lines++;
            end  // comment lines fall through here
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        req_valid    <= 1'b0;
        req_load_op  <= '0;
        req_store_op <= '0;
        host_we      <= 1'b0;
    endtask

    task automatic issue_request(input int i);
        load_op_t  lop;
        store_op_t sop;
        lop = (t_kind[i] == tok_t'("S")) ? '0 : load_code(t_op[i]);
        sop = (t_kind[i] == tok_t'("S") || t_kind[i] == tok_t'("X")) ? store_code(t_op[i]) : '0;
        if (lop == '0 && sop == '0) begin
            stop_with($sformatf("unknown op in trace line %0s", t_name[i]));
        end
        @(posedge clk);
        req_valid    <= 1'b1;
        req_load_op  <= lop;
        req_store_op <= sop;
        req_addr     <= t_a[i][7:0];
        req_rt       <= t_b[i][2:0];
        host_we      <= 1'b0;
    endtask

    task automatic host_write(input int i);
        @(posedge clk);
        drive_idle();  // lets a pending writeback retire first
        @(posedge clk);
        host_we    <= 1'b1;
        host_idx   <= t_a[i][2:0];
        host_wdata <= t_b[i];
    endtask

    // register result is visible once the writeback edge has passed
    task automatic observe_reg(input int i, input logic [2:0] idx);
        @(posedge clk);
        drive_idle();
        obs_idx <= idx;
        @(negedge clk);
        check_value(t_name[i], 32'(0), 32'(exc_valid));
        @(posedge clk);
        @(negedge clk);
        check_value(t_name[i], t_exp[i], obs_data);
    endtask

    task automatic expect_exception(input int i);
        issue_request(i);
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_value(t_name[i], 32'(1), 32'(exc_valid));
        check_value(t_name[i], 32'(store_code(t_op[i]) != '0), 32'(exc_store));
        check_value(t_name[i], t_exp[i], 32'(exc_addr));
        @(posedge clk);
        @(negedge clk);
        check_value(t_name[i], 32'(0), 32'(exc_valid));  // single-cycle pulse
    endtask

    initial begin
        trace_ready = 1'b0;
        req_valid    = 1'b0;
        req_load_op  = '0;
        req_store_op = '0;
        req_addr     = '0;
        req_rt       = '0;
        host_we      = 1'b0;
        host_idx     = '0;
        host_wdata   = '0;
        obs_idx      = '0;
        read_trace();
        trace_ready = 1'b1;
        @(posedge clk);
        while (rst) @(posedge clk);
        for (int i = 0; i < n_lines; i++) begin
            case (t_kind[i])
                tok_t'("H"): host_write(i);
                tok_t'("S"): issue_request(i);
                tok_t'("F"): issue_request(i);  // no wait so a store can follow at once
                tok_t'("L"): begin
                    issue_request(i);
                    observe_reg(i, t_b[i][2:0]);
                end
                tok_t'("O"): observe_reg(i, t_a[i][2:0]);
                tok_t'("X"): expect_exception(i);
                default:     stop_with($sformatf("unknown kind in trace line %0s", t_name[i]));
            endcase
        end
        @(posedge clk);
        drive_idle();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // watchdog budget grows with the trace length
    initial begin
        wait (trace_ready);
        repeat (n_lines * CYCLES_PER_LINE + 10) @(posedge clk);
        $display("timeout: the trace did not finish in %0d cycles",
                 n_lines * CYCLES_PER_LINE + 10);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run from the project root; a $fatal in the run gives a failing status
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module tb_lsu \
    -o sim_lsu && ./obj_dir/sim_lsu || exit 1

//--- src/data_ram.sv
`default_nettype none

module data_ram (
    input  wire logic                   clk,
    input  wire lsu_mem_pkg::byte_en_t  we,
    input  wire lsu_mem_pkg::mem_addr_t addr,
    input  wire lsu_mem_pkg::word_t     wdata,
    output lsu_mem_pkg::word_t          rdata
);
    import lsu_mem_pkg::*;

    word_t                    mem [RAM_WORDS];
    logic [WORD_IDX_BITS-1:0] word_idx;

    assign word_idx = addr[2 +: WORD_IDX_BITS];  // byte offset bits dropped

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (we[b]) begin
                mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // registered read returns the old data on a same-edge write
    always_ff @(posedge clk) begin
        rdata <= mem[word_idx];
    end

endmodule

`default_nettype wire

//--- src/load_align.sv
`default_nettype none

module load_align (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire lsu_isa_pkg::load_op_t  req_load_op,
    input  wire lsu_mem_pkg::mem_addr_t req_addr,
    input  wire lsu_mem_pkg::reg_idx_t  req_rt,
    input  wire lsu_mem_pkg::word_t     ram_rdata,
    input  wire logic                   ades,
    output logic                        adel,
    output logic                        wb_valid,
    output lsu_mem_pkg::reg_idx_t       wb_idx,
    output lsu_mem_pkg::byte_en_t       wb_be,
    output lsu_mem_pkg::word_t          wb_data,
    output logic                        exc_valid,
    output logic                        exc_store,
    output lsu_mem_pkg::mem_addr_t      exc_addr
);
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;

    logic     lw;
    logic     lb;
    logic     lbu;
    logic     lh;
    logic     lhu;
    logic     lwl;
    logic     lwr;
    logic     is_load;
    byte_en_t addr_d;
    rshift_t  rshift;
    ext_op_t  ext_op;
    byte_en_t reg_be;
    rshift_t  rshift_q;
    ext_op_t  ext_q;
    word_t    rot_data;

    assign lw  = req_valid && ((req_load_op & LOAD_LW) != '0);
    assign lb  = req_valid && ((req_load_op & LOAD_LB) != '0);
    assign lbu = req_valid && ((req_load_op & LOAD_LBU) != '0);
    assign lh  = req_valid && ((req_load_op & LOAD_LH) != '0);
    assign lhu = req_valid && ((req_load_op & LOAD_LHU) != '0);
    assign lwl = req_valid && ((req_load_op & LOAD_LWL) != '0);
    assign lwr = req_valid && ((req_load_op & LOAD_LWR) != '0);

    assign is_load = lw || lb || lbu || lh || lhu || lwl || lwr;
    assign addr_d  = 4'b0001 << req_addr[1:0];

    // lwl brings byte addr up to lane 3, the rest bring it down to lane 0
    assign rshift = ({4{lw}}                            & ROT_0)
                  | ({4{lb || lbu || lh || lhu || lwr}} & addr_d)
                  | ({4{lwl}}                           & {addr_d[2:0], addr_d[3]});

    assign ext_op = ({5{lb}}               & EXT_SB)
                  | ({5{lbu}}              & EXT_ZB)
                  | ({5{lh}}               & EXT_SH)
                  | ({5{lhu}}              & EXT_ZH)
                  | ({5{lw || lwl || lwr}} & EXT_NONE);

    assign reg_be = ({4{lw || lb || lbu || lh || lhu}} & 4'b1111)
                  | ({4{lwl}} & {1'b1, ~addr_d[0], addr_d[2] || addr_d[3], addr_d[3]})
                  | ({4{lwr}} & {addr_d[0], addr_d[0] || addr_d[1], ~addr_d[3], 1'b1});

    assign adel = lw && !addr_d[0]
               || (lh || lhu) && req_addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_valid  <= is_load && !adel;  // misaligned load never reaches writeback
            exc_valid <= adel || ades;
        end
    end

    always_ff @(posedge clk) begin
        rshift_q  <= rshift;
        ext_q     <= ext_op;
        wb_be     <= reg_be;
        wb_idx    <= req_rt;
        exc_store <= ades;
        exc_addr  <= req_addr;
    end

    // ram_rdata here belongs to the load sampled at the last edge
    assign rot_data = rotate_bytes(rshift_q, ram_rdata);

    always_comb begin
        case (ext_q)
            EXT_SB:  wb_data = {{24{rot_data[7]}}, rot_data[7:0]};
            EXT_ZB:  wb_data = {24'b0, rot_data[7:0]};
            EXT_SH:  wb_data = {{16{rot_data[15]}}, rot_data[15:0]};
            EXT_ZH:  wb_data = {16'b0, rot_data[15:0]};
            default: wb_data = rot_data;  // lw, lwl, lwr
        endcase
    end

    load_op_onehot: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> $onehot0(req_load_op))
        else $error("load_align: more than one load op in a request");

endmodule

`default_nettype wire

//--- src/lsu_isa_pkg.sv
`default_nettype none

package lsu_isa_pkg;

    typedef logic [6:0] load_op_t;   // {lw, lb, lbu, lh, lhu, lwl, lwr}
    typedef logic [4:0] store_op_t;  // {sw, sb, sh, swl, swr}
    typedef logic [3:0] rshift_t;    // one-hot rotate right by 0..3 bytes
    typedef logic [4:0] ext_op_t;    // {sign b, zero b, sign h, zero h, none}

    localparam load_op_t LOAD_LW  = 7'b100_0000;
    localparam load_op_t LOAD_LB  = 7'b010_0000;
    localparam load_op_t LOAD_LBU = 7'b001_0000;
    localparam load_op_t LOAD_LH  = 7'b000_1000;
    localparam load_op_t LOAD_LHU = 7'b000_0100;
    localparam load_op_t LOAD_LWL = 7'b000_0010;
    localparam load_op_t LOAD_LWR = 7'b000_0001;

    localparam store_op_t STORE_SW  = 5'b10000;
    localparam store_op_t STORE_SB  = 5'b01000;
    localparam store_op_t STORE_SH  = 5'b00100;
    localparam store_op_t STORE_SWL = 5'b00010;
    localparam store_op_t STORE_SWR = 5'b00001;

    localparam rshift_t ROT_0 = 4'b0001;
    localparam rshift_t ROT_1 = 4'b0010;
    localparam rshift_t ROT_2 = 4'b0100;
    localparam rshift_t ROT_3 = 4'b1000;

    localparam ext_op_t EXT_SB   = 5'b10000;
    localparam ext_op_t EXT_ZB   = 5'b01000;
    localparam ext_op_t EXT_SH   = 5'b00100;
    localparam ext_op_t EXT_ZH   = 5'b00010;
    localparam ext_op_t EXT_NONE = 5'b00001;

    // byte rotate right used by both the load and store sides
    function automatic logic [31:0] rotate_bytes(input rshift_t amt, input logic [31:0] data);
        case (amt)
            ROT_1:   rotate_bytes = {data[7:0], data[31:8]};
            ROT_2:   rotate_bytes = {data[15:0], data[31:16]};
            ROT_3:   rotate_bytes = {data[23:0], data[31:24]};
            default: rotate_bytes = data;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/lsu_mem_pkg.sv
`default_nettype none

package lsu_mem_pkg;

    localparam int BYTE_LANES = 4;
    localparam int RAM_WORDS  = 64;
    localparam int REG_COUNT  = 8;

    localparam int WORD_IDX_BITS = $clog2(RAM_WORDS);  // word part of a byte address
    localparam int REG_IDX_BITS  = $clog2(REG_COUNT);

    typedef logic [8*BYTE_LANES-1:0]  word_t;
    typedef logic [BYTE_LANES-1:0]    byte_en_t;
    typedef logic [WORD_IDX_BITS+1:0] mem_addr_t;       // byte address
    typedef logic [REG_IDX_BITS-1:0]  reg_idx_t;

endpackage

`default_nettype wire

//--- src/lsu_top.sv
`default_nettype none

module lsu_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire lsu_isa_pkg::load_op_t  req_load_op,
    input  wire lsu_isa_pkg::store_op_t req_store_op,
    input  wire lsu_mem_pkg::mem_addr_t req_addr,
    input  wire lsu_mem_pkg::reg_idx_t  req_rt,
    input  wire logic                   host_we,
    input  wire lsu_mem_pkg::reg_idx_t  host_idx,
    input  wire lsu_mem_pkg::word_t     host_wdata,
    input  wire lsu_mem_pkg::reg_idx_t  obs_idx,
    output lsu_mem_pkg::word_t          obs_data,
    output logic                        exc_valid,
    output logic                        exc_store,
    output lsu_mem_pkg::mem_addr_t      exc_addr
);
    import lsu_mem_pkg::*;

    word_t    st_data;
    byte_en_t ram_we;
    word_t    ram_wdata;
    word_t    ram_rdata;
    logic     ades;
    logic     adel;
    logic     wb_valid;
    reg_idx_t wb_idx;
    byte_en_t wb_be;
    word_t    wb_data;

    store_align u_store_align (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_store_op (req_store_op),
        .req_addr     (req_addr),
        .st_data      (st_data),
        .ram_we       (ram_we),
        .ram_wdata    (ram_wdata),
        .ades         (ades)
    );

    load_align u_load_align (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_load_op (req_load_op),
        .req_addr    (req_addr),
        .req_rt      (req_rt),
        .ram_rdata   (ram_rdata),
        .ades        (ades),
        .adel        (adel),
        .wb_valid    (wb_valid),
        .wb_idx      (wb_idx),
        .wb_be       (wb_be),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_store   (exc_store),
        .exc_addr    (exc_addr)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (req_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    reg_file_fwd u_reg_file_fwd (
        .clk        (clk),
        .rst        (rst),
        .host_we    (host_we),
        .host_idx   (host_idx),
        .host_wdata (host_wdata),
        .wb_valid   (wb_valid),
        .wb_idx     (wb_idx),
        .wb_be      (wb_be),
        .wb_data    (wb_data),
        .rd_idx     (req_rt),     // store data register
        .obs_idx    (obs_idx),
        .rd_data    (st_data),
        .obs_data   (obs_data)
    );

    // the two aligners never both refuse the same request
    one_addr_error: assert property (@(posedge clk) disable iff (rst)
        !(adel && ades))
        else $error("lsu_top: load and store address error in one request");

endmodule

`default_nettype wire

//--- src/reg_file_fwd.sv
`default_nettype none

module reg_file_fwd (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  host_we,
    input  wire lsu_mem_pkg::reg_idx_t host_idx,
    input  wire lsu_mem_pkg::word_t    host_wdata,
    input  wire logic                  wb_valid,
    input  wire lsu_mem_pkg::reg_idx_t wb_idx,
    input  wire lsu_mem_pkg::byte_en_t wb_be,
    input  wire lsu_mem_pkg::word_t    wb_data,
    input  wire lsu_mem_pkg::reg_idx_t rd_idx,
    input  wire lsu_mem_pkg::reg_idx_t obs_idx,
    output lsu_mem_pkg::word_t         rd_data,
    output lsu_mem_pkg::word_t         obs_data
);
    import lsu_mem_pkg::*;

    word_t    regs [REG_COUNT];
    byte_en_t fwd_en;  // lanes taken from the pending writeback
    word_t    stored;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (host_we) begin
            regs[host_idx] <= host_wdata;
        end else if (wb_valid) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (wb_be[b]) begin
                    regs[wb_idx][8*b +: 8] <= wb_data[8*b +: 8];  // lwl/lwr keep the rest
                end
            end
        end
    end

    assign stored = regs[rd_idx];
    assign fwd_en = wb_be & {BYTE_LANES{wb_valid && (wb_idx == rd_idx)}};

    // per-byte merge of the load that writes back at the coming edge
    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            rd_data[8*b +: 8] = fwd_en[b] ? wb_data[8*b +: 8] : stored[8*b +: 8];
        end
    end

    assign obs_data = regs[obs_idx];

    host_vs_writeback: assert property (@(posedge clk) disable iff (rst)
        !(host_we && wb_valid))
        else $error("reg_file_fwd: host write collides with a load writeback");

endmodule

`default_nettype wire

//--- src/store_align.sv
`default_nettype none

module store_align (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   req_valid,
    input  wire lsu_isa_pkg::store_op_t req_store_op,
    input  wire lsu_mem_pkg::mem_addr_t req_addr,
    input  wire lsu_mem_pkg::word_t     st_data,
    output lsu_mem_pkg::byte_en_t       ram_we,
    output lsu_mem_pkg::word_t          ram_wdata,
    output logic                        ades
);
    import lsu_isa_pkg::*;
    import lsu_mem_pkg::*;

    logic     sw;
    logic     sb;
    logic     sh;
    logic     swl;
    logic     swr;
    byte_en_t addr_d;     // one-hot lane of the low address bits
    rshift_t  rshift;
    byte_en_t lane_mask;

    assign sw  = req_valid && ((req_store_op & STORE_SW) != '0);
    assign sb  = req_valid && ((req_store_op & STORE_SB) != '0);
    assign sh  = req_valid && ((req_store_op & STORE_SH) != '0);
    assign swl = req_valid && ((req_store_op & STORE_SWL) != '0);
    assign swr = req_valid && ((req_store_op & STORE_SWR) != '0);

    assign addr_d = 4'b0001 << req_addr[1:0];

    // register lane 0 (sb, sh, swr) or lane 3 (swl) has to land on lane addr
    assign rshift = ({4{sw}}              & ROT_0)
                  | ({4{sb || sh || swr}} & {addr_d[1], addr_d[2], addr_d[3], addr_d[0]})
                  | ({4{swl}}             & {addr_d[0], addr_d[1], addr_d[2], addr_d[3]});

    // swl covers lanes 0..addr, swr covers lanes addr..3
    assign lane_mask = ({4{sw}}  & 4'b1111)
                     | ({4{sb}}  & addr_d)
                     | ({4{sh}}  & {{2{addr_d[2]}}, {2{addr_d[0]}}})
                     | ({4{swl}} & {addr_d[3], addr_d[3] || addr_d[2], ~addr_d[0], 1'b1})
                     | ({4{swr}} & {1'b1, ~addr_d[3], addr_d[0] || addr_d[1], addr_d[0]});

    assign ades = sw && !addr_d[0]
               || sh && req_addr[0];

    assign ram_we    = lane_mask & {BYTE_LANES{~ades}};  // refused store leaves the RAM alone
    assign ram_wdata = rotate_bytes(rshift, st_data);

    store_op_onehot: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> $onehot0(req_store_op))
        else $error("store_align: more than one store op in a request");

endmodule

`default_nettype wire

//--- vlog.f
src/lsu_isa_pkg.sv
src/lsu_mem_pkg.sv
src/store_align.sv
src/load_align.sv
src/data_ram.sv
src/reg_file_fwd.sv
src/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_lsu.sv
